// File: common/heapGeometryPkg.sv
/*
  Heap geometry. arrayCount and arrayLength are powers of two, so every
  handle and index value addresses a real slot.
*/
`default_nettype none

package heapGeometryPkg;

  localparam int arrayCount   = 4;                        // Array handles
  localparam int arrayLength  = 8;                        // Max elements per array
  localparam int dataWidth    = 16;                       // Element width

  localparam int arrayIdWidth = $clog2(arrayCount);
  localparam int indexWidth   = $clog2(arrayLength);
  localparam int sizeWidth    = $clog2(arrayLength + 1);  // Holds 0 to arrayLength

  typedef logic [arrayIdWidth-1:0] arrayIdT;
  typedef logic [indexWidth-1:0]   indexT;
  typedef logic [sizeWidth-1:0]    sizeT;
  typedef logic [dataWidth-1:0]    dataT;

endpackage

`default_nettype wire

// File: common/heapOpPkg.sv
/*
  Operation and error codes of the heap request interface.
  Opcodes above bitAnd change no state and return no defined data.
*/
`default_nettype none

package heapOpPkg;

  typedef enum logic [4:0] {
    clearAll,    // Empty the whole directory
    write,       // Store an element, may grow the array
    read,        // Fetch an element
    size,        // Current array size
    push,        // Append at the size
    pop,         // Remove the last element
    alloc,       // New or recycled handle
    free,        // Return a handle
    add,         // Returns new value
    addAfter,    // Returns old value
    subtract,
    subAfter,
    shiftLeft,   // Amount taken from dataIn
    shiftRight,
    bitNot,
    bitOr,
    bitXor,
    bitAnd
  } opCodeT;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,  // Handle at or above the high-water count
    errFreed,         // Handle was freed, catches double free
    errOutOfBounds,   // Index at or past the size
    errFull,          // Push on a full array
    errEmpty,         // Pop on an empty array
    errOutOfMemory    // No handle left
  } errorCodeT;

  // Operations whose element must lie inside the array
  localparam logic [31:0] isElementOp =
      (32'd1 << read)     | (32'd1 << add)       | (32'd1 << addAfter)   |
      (32'd1 << subtract) | (32'd1 << subAfter)  | (32'd1 << shiftLeft)  |
      (32'd1 << shiftRight) | (32'd1 << bitNot)  | (32'd1 << bitOr)      |
      (32'd1 << bitXor)   | (32'd1 << bitAnd);

endpackage

`default_nettype wire

// File: heap/elementStore.sv
/*
  Element memory, arrayCount blocks of arrayLength words.
  Read data appears one cycle after storeReadEnable and then holds.
*/
`timescale 1ns/100ps
`default_nettype none

module elementStore (
  input  wire                           clock,
  input  wire                           storeReadEnable,
  input  wire heapGeometryPkg::indexT   storeReadIndex,
  input  wire                           storeWriteEnable,
  input  wire heapGeometryPkg::indexT   storeWriteIndex,
  input  wire heapGeometryPkg::dataT    storeWriteData,
  input  wire heapGeometryPkg::arrayIdT queryId,
  output heapGeometryPkg::dataT         readData
);

  // Flat array, handle in the upper address bits
  heapGeometryPkg::dataT memory [heapGeometryPkg::arrayCount * heapGeometryPkg::arrayLength];

  always_ff @(posedge clock) begin
    if (storeWriteEnable) memory[{queryId, storeWriteIndex}] <= storeWriteData;
    if (storeReadEnable)  readData <= memory[{queryId, storeReadIndex}];  // Registered read
  end

endmodule

`default_nettype wire

// File: heap/elementAlu.sv
/*
  Read-modify-write arithmetic, purely combinational.
  Shifts use the whole operand, so amounts of dataWidth or more give zero.
*/
`timescale 1ns/100ps
`default_nettype none

module elementAlu (
  input  wire heapOpPkg::opCodeT     aluOperation,
  input  wire heapGeometryPkg::dataT aluOperand,
  input  wire heapGeometryPkg::dataT readData,
  output heapGeometryPkg::dataT      newValue,
  output heapGeometryPkg::dataT      returnValue
);

  always_comb begin
    case (aluOperation)
      heapOpPkg::add, heapOpPkg::addAfter:      newValue = readData + aluOperand;
      heapOpPkg::subtract, heapOpPkg::subAfter: newValue = readData - aluOperand;
      heapOpPkg::shiftLeft:  newValue = readData << aluOperand;
      heapOpPkg::shiftRight: newValue = readData >> aluOperand;  // Logical shift
      heapOpPkg::bitNot:     newValue = ~readData;
      heapOpPkg::bitOr:      newValue = readData | aluOperand;
      heapOpPkg::bitXor:     newValue = readData ^ aluOperand;
      heapOpPkg::bitAnd:     newValue = readData & aluOperand;
      default:               newValue = readData;  // Read passes the element through
    endcase
  end

  // After forms hand back the element as it was
  assign returnValue = (aluOperation == heapOpPkg::addAfter ||
                        aluOperation == heapOpPkg::subAfter) ? readData : newValue;

endmodule

`default_nettype wire

// File: heap/arrayDirectory.sv
/*
  Handle bookkeeping. Commits are applied without checks, so the caller
  must only free allocated handles and only alloc when allocAvailable.
*/
`timescale 1ns/100ps
`default_nettype none

module arrayDirectory (
  input  wire                           clock,
  input  wire                           resetN,
  input  wire heapGeometryPkg::arrayIdT queryId,
  input  wire                           commitAlloc,
  input  wire                           commitFree,
  input  wire                           commitClear,
  input  wire                           commitSize,
  input  wire heapGeometryPkg::sizeT    newSize,
  output logic                          arrayAllocated,
  output logic                          arrayKnown,
  output heapGeometryPkg::sizeT         arraySize,
  output heapGeometryPkg::arrayIdT      allocHandle,
  output logic                          allocAvailable
);

  logic [heapGeometryPkg::arrayCount-1:0] allocBits;       // One per handle
  logic [heapGeometryPkg::arrayIdWidth:0] freeTop;         // Entries on the free stack
  logic [heapGeometryPkg::arrayIdWidth:0] allocCount;      // High-water mark
  heapGeometryPkg::arrayIdT freeStack [heapGeometryPkg::arrayCount];
  heapGeometryPkg::sizeT    sizeTable [heapGeometryPkg::arrayCount];
  heapGeometryPkg::arrayIdT stackTop;

  assign stackTop = heapGeometryPkg::arrayIdT'(freeTop - 1'b1);

  // Combinational answers for the queried handle
  assign arrayAllocated = allocBits[queryId];
  assign arrayKnown     = {1'b0, queryId} < allocCount;
  assign arraySize      = sizeTable[queryId];

  // Most recently freed handle first, else the next new one
  assign allocHandle    = (freeTop != '0) ? freeStack[stackTop] :
                          heapGeometryPkg::arrayIdT'(allocCount);
  assign allocAvailable = freeTop != '0 || allocCount < heapGeometryPkg::arrayCount;

  // ------------------------------------------------------------------------
  // Allocation state
  // ------------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocBits  <= '0;
      freeTop    <= '0;
      allocCount <= '0;
    end else if (commitClear) begin  // Whole heap empty
      allocBits  <= '0;
      freeTop    <= '0;
      allocCount <= '0;
    end else if (commitAlloc) begin
      allocBits[allocHandle] <= 1'b1;
      if (freeTop != '0) freeTop <= freeTop - 1'b1;  // Recycle
      else allocCount <= allocCount + 1'b1;          // Fresh handle
    end else if (commitFree) begin
      allocBits[queryId] <= 1'b0;
      freeTop            <= freeTop + 1'b1;
    end
  end

  // Stack entries and sizes
  always_ff @(posedge clock) begin
    if (commitFree) freeStack[heapGeometryPkg::arrayIdT'(freeTop)] <= queryId;
    if (commitAlloc) sizeTable[allocHandle] <= '0;  // New array starts empty
    else if (commitSize) sizeTable[queryId] <= newSize;
  end

endmodule

`default_nettype wire

// File: heap/heapControl.sv
/*
  One request in flight. The response comes two edges after acceptance
  and cannot be stalled. Store read is issued at acceptance, from the raw
  request, so the element is on readData while the request is checked.
*/
`timescale 1ns/100ps
`default_nettype none

module heapControl (
  input  wire                       clock,
  input  wire                       resetN,
  input  wire                       requestValid,
  input  wire heapOpPkg::opCodeT    operation,
  input  wire heapGeometryPkg::arrayIdT arrayId,
  input  wire heapGeometryPkg::indexT   elementIndex,
  input  wire heapGeometryPkg::dataT    dataIn,
  input  wire                       arrayAllocated,
  input  wire                       arrayKnown,
  input  wire heapGeometryPkg::sizeT    arraySize,
  input  wire heapGeometryPkg::arrayIdT allocHandle,
  input  wire                       allocAvailable,
  input  wire heapGeometryPkg::dataT    readData,
  input  wire heapGeometryPkg::dataT    newValue,
  input  wire heapGeometryPkg::dataT    returnValue,
  output logic                      ready,
  output logic                      responseValid,
  output heapGeometryPkg::dataT     dataOut,
  output heapOpPkg::errorCodeT      errorCode,
  output heapGeometryPkg::arrayIdT  queryId,
  output logic                      commitAlloc,
  output logic                      commitFree,
  output logic                      commitClear,
  output logic                      commitSize,
  output heapGeometryPkg::sizeT     newSize,
  output logic                      storeReadEnable,
  output heapGeometryPkg::indexT    storeReadIndex,
  output logic                      storeWriteEnable,
  output heapGeometryPkg::indexT    storeWriteIndex,
  output heapGeometryPkg::dataT     storeWriteData,
  output heapOpPkg::opCodeT         aluOperation,
  output heapGeometryPkg::dataT     aluOperand
);

  logic                     executing;   // Cycle 1, checks and commit
  logic                     responding;  // Cycle 2, response on the port
  logic                     accept;
  logic                     legal;
  heapOpPkg::errorCodeT     checkError;
  heapGeometryPkg::dataT    responseData;
  heapGeometryPkg::sizeT    indexPlusOne;
  heapOpPkg::opCodeT        reqOp;
  heapGeometryPkg::arrayIdT reqId;
  heapGeometryPkg::indexT   reqIndex;
  heapGeometryPkg::dataT    reqData;

  assign ready         = !executing && !responding;
  assign accept        = requestValid && ready;
  assign responseValid = responding;

  // Directory sees the raw handle while idle, the held one after
  assign queryId = ready ? arrayId : reqId;

  // ------------------------------------------------------------------------
  // Element read at acceptance
  // ------------------------------------------------------------------------
  assign storeReadEnable = accept;
  assign storeReadIndex  = (operation == heapOpPkg::pop) ?
                           heapGeometryPkg::indexT'(arraySize - 1'b1) : elementIndex;

  always_ff @(posedge clock) begin
    if (accept) begin  // Held request
      reqOp    <= operation;
      reqId    <= arrayId;
      reqIndex <= elementIndex;
      reqData  <= dataIn;
    end
  end

  // ------------------------------------------------------------------------
  // Legality checks, first failure wins
  // ------------------------------------------------------------------------
  always_comb begin
    checkError = heapOpPkg::errNone;
    if (reqOp == heapOpPkg::alloc) begin
      if (!allocAvailable) checkError = heapOpPkg::errOutOfMemory;
    end else if (reqOp != heapOpPkg::clearAll) begin
      if (!arrayKnown) checkError = heapOpPkg::errNotAllocated;
      else if (!arrayAllocated) checkError = heapOpPkg::errFreed;
      else if (heapOpPkg::isElementOp[reqOp] && indexPlusOne > arraySize)
        checkError = heapOpPkg::errOutOfBounds;
      else if (reqOp == heapOpPkg::push &&
               arraySize == heapGeometryPkg::sizeT'(heapGeometryPkg::arrayLength))
        checkError = heapOpPkg::errFull;
      else if (reqOp == heapOpPkg::pop && arraySize == '0)
        checkError = heapOpPkg::errEmpty;
    end
  end

  assign legal        = executing && checkError == heapOpPkg::errNone;
  assign indexPlusOne = heapGeometryPkg::sizeT'(reqIndex) + 1'b1;

  // Directory commits
  assign commitAlloc = legal && reqOp == heapOpPkg::alloc;
  assign commitFree  = legal && reqOp == heapOpPkg::free;
  assign commitClear = legal && reqOp == heapOpPkg::clearAll;
  assign commitSize  = legal && (reqOp == heapOpPkg::write || reqOp == heapOpPkg::push ||
                                 reqOp == heapOpPkg::pop);

  always_comb begin
    case (reqOp)
      heapOpPkg::write: newSize = (indexPlusOne > arraySize) ? indexPlusOne : arraySize;
      heapOpPkg::push:  newSize = arraySize + 1'b1;
      default:          newSize = arraySize - 1'b1;  // Pop
    endcase
  end

  // Store write, push goes to the slot at the size
  assign storeWriteEnable = legal && reqOp != heapOpPkg::read &&
                            (reqOp == heapOpPkg::write || reqOp == heapOpPkg::push ||
                             heapOpPkg::isElementOp[reqOp]);
  assign storeWriteIndex  = (reqOp == heapOpPkg::push) ?
                            heapGeometryPkg::indexT'(arraySize) : reqIndex;
  assign storeWriteData   = (reqOp == heapOpPkg::write || reqOp == heapOpPkg::push) ?
                            reqData : newValue;

  assign aluOperation = reqOp;
  assign aluOperand   = reqData;

  always_comb begin
    case (reqOp)
      heapOpPkg::write, heapOpPkg::push: responseData = reqData;
      heapOpPkg::size:  responseData = heapGeometryPkg::dataT'(arraySize);
      heapOpPkg::pop:   responseData = readData;
      heapOpPkg::alloc: responseData = heapGeometryPkg::dataT'(allocHandle);
      heapOpPkg::free, heapOpPkg::clearAll: responseData = '0;
      default:          responseData = returnValue;  // Read and element ops
    endcase
  end

  // ------------------------------------------------------------------------
  // Busy sequence and registered response
  // ------------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      executing  <= 1'b0;
      responding <= 1'b0;
      dataOut    <= '0;
      errorCode  <= heapOpPkg::errNone;
    end else begin
      executing  <= accept;
      responding <= executing;
      if (executing) begin
        dataOut   <= legal ? responseData : '0;  // Zero on any error
        errorCode <= checkError;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/heapMemory.sv
/*
  Heap of fixed-size arrays. Valid/ready request, response exactly two
  edges after acceptance, one operation in flight at a time.
*/
`timescale 1ns/100ps
`default_nettype none

module heapMemory (
  input  wire                           clock,
  input  wire                           resetN,
  input  wire                           requestValid,
  input  wire heapOpPkg::opCodeT        operation,
  input  wire heapGeometryPkg::arrayIdT arrayId,
  input  wire heapGeometryPkg::indexT   elementIndex,
  input  wire heapGeometryPkg::dataT    dataIn,
  output logic                          ready,
  output logic                          responseValid,
  output heapGeometryPkg::dataT         dataOut,
  output heapOpPkg::errorCodeT          errorCode
);

  // Directory links
  logic                     arrayAllocated, arrayKnown, allocAvailable;
  logic                     commitAlloc, commitFree, commitClear, commitSize;
  heapGeometryPkg::sizeT    arraySize, newSize;
  heapGeometryPkg::arrayIdT allocHandle, queryId;
  // Store and ALU links
  logic                     storeReadEnable, storeWriteEnable;
  heapGeometryPkg::indexT   storeReadIndex, storeWriteIndex;
  heapGeometryPkg::dataT    storeWriteData, readData, newValue, returnValue, aluOperand;
  heapOpPkg::opCodeT        aluOperation;

  heapControl heapControl_inst (
    .clock, .resetN, .requestValid, .operation, .arrayId, .elementIndex, .dataIn,
    .arrayAllocated, .arrayKnown, .arraySize, .allocHandle, .allocAvailable,
    .readData, .newValue, .returnValue,
    .ready, .responseValid, .dataOut, .errorCode, .queryId,
    .commitAlloc, .commitFree, .commitClear, .commitSize, .newSize,
    .storeReadEnable, .storeReadIndex, .storeWriteEnable, .storeWriteIndex,
    .storeWriteData, .aluOperation, .aluOperand
  );

  arrayDirectory arrayDirectory_inst (
    .clock, .resetN, .queryId,
    .commitAlloc, .commitFree, .commitClear, .commitSize, .newSize,
    .arrayAllocated, .arrayKnown, .arraySize, .allocHandle, .allocAvailable
  );

  elementStore elementStore_inst (
    .clock, .storeReadEnable, .storeReadIndex,
    .storeWriteEnable, .storeWriteIndex, .storeWriteData,
    .queryId, .readData
  );

  elementAlu elementAlu_inst (
    .aluOperation, .aluOperand, .readData, .newValue, .returnValue
  );

endmodule

`default_nettype wire

// File: verif/heapMemoryTb.sv
/*
  Testbench for heapMemory. A reference model predicts every response at
  acceptance. Never reads an element that was not written first, since
  store contents are undefined after power-up.
*/
`timescale 1ns/100ps
`default_nettype none

module heapMemoryTb;

  localparam int randomOps    = 24;                      // Element op and readback pairs
  localparam int requestCount = 15 + 20 + 8 + 2 * randomOps + 7;
  localparam int cycleLimit   = 3 * requestCount + 50;   // Three edges per request

  logic                     clock = 1'b0;
  logic                     resetN;
  logic                     requestValid;
  heapOpPkg::opCodeT        operation;
  heapGeometryPkg::arrayIdT arrayId;
  heapGeometryPkg::indexT   elementIndex;
  heapGeometryPkg::dataT    dataIn;
  logic                     ready;
  logic                     responseValid;
  heapGeometryPkg::dataT    dataOut;
  heapOpPkg::errorCodeT     errorCode;

  integer seed = 92165;
  int     cycleCount;
  int     mismatchErrors = 0;
  int     protocolErrors = 0;
  int     otherErrors    = 0;

  // Reference model of the heap
  int                       modelCount;
  bit                       modelAllocated [heapGeometryPkg::arrayCount];
  int                       modelSize      [heapGeometryPkg::arrayCount];
  heapGeometryPkg::dataT    modelMem       [heapGeometryPkg::arrayCount]
                                           [heapGeometryPkg::arrayLength];
  heapGeometryPkg::arrayIdT modelFree      [$];  // Back is the most recent free

  // Predictions waiting for their response
  heapGeometryPkg::dataT    expDataQueue  [$];
  heapOpPkg::errorCodeT     expErrorQueue [$];
  heapOpPkg::opCodeT        expOpQueue    [$];

  always #50 clock = ~clock;  // 100 ns period

  heapMemory heapMemory_inst (
    .clock, .resetN, .requestValid, .operation, .arrayId, .elementIndex, .dataIn,
    .ready, .responseValid, .dataOut, .errorCode
  );

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic heapGeometryPkg::dataT applyElementOp(input heapOpPkg::opCodeT op,
      input heapGeometryPkg::dataT oldValue, input heapGeometryPkg::dataT operand);
    case (op)
      heapOpPkg::add, heapOpPkg::addAfter:      return oldValue + operand;
      heapOpPkg::subtract, heapOpPkg::subAfter: return oldValue - operand;
      heapOpPkg::shiftLeft:
        return (operand >= heapGeometryPkg::dataWidth) ? '0 : oldValue << operand;
      heapOpPkg::shiftRight:
        return (operand >= heapGeometryPkg::dataWidth) ? '0 : oldValue >> operand;
      heapOpPkg::bitNot: return ~oldValue;
      heapOpPkg::bitOr:  return oldValue | operand;
      heapOpPkg::bitXor: return oldValue ^ operand;
      default:           return oldValue & operand;  // bitAnd
    endcase
  endfunction

  task automatic predictResponse(input heapOpPkg::opCodeT op,
      input heapGeometryPkg::arrayIdT id, input heapGeometryPkg::indexT idx,
      input heapGeometryPkg::dataT data, output heapGeometryPkg::dataT expData,
      output heapOpPkg::errorCodeT expError);
    heapGeometryPkg::dataT    oldValue;
    heapGeometryPkg::dataT    newValue;
    heapGeometryPkg::arrayIdT handle;
    expData  = '0;  // Zero on any error
    expError = heapOpPkg::errNone;
    oldValue = modelMem[id][idx];
    if (op == heapOpPkg::clearAll) begin
      modelCount = 0;
      modelFree.delete();
      foreach (modelAllocated[i]) modelAllocated[i] = 1'b0;
    end else if (op == heapOpPkg::alloc) begin
      if (modelFree.size() != 0) handle = modelFree.pop_back();  // Recycle, LIFO
      else if (modelCount < heapGeometryPkg::arrayCount) begin
        handle = heapGeometryPkg::arrayIdT'(modelCount);
        modelCount++;
      end else expError = heapOpPkg::errOutOfMemory;
      if (expError == heapOpPkg::errNone) begin
        modelAllocated[handle] = 1'b1;
        modelSize[handle]      = 0;  // New array is empty
        expData                = heapGeometryPkg::dataT'(handle);
      end
    end else if (int'(id) >= modelCount) expError = heapOpPkg::errNotAllocated;
    else if (!modelAllocated[id]) expError = heapOpPkg::errFreed;
    else if (heapOpPkg::isElementOp[op] && int'(idx) >= modelSize[id])
      expError = heapOpPkg::errOutOfBounds;
    else if (op == heapOpPkg::push && modelSize[id] == heapGeometryPkg::arrayLength)
      expError = heapOpPkg::errFull;
    else if (op == heapOpPkg::pop && modelSize[id] == 0) expError = heapOpPkg::errEmpty;
    else begin
      case (op)
        heapOpPkg::write: begin
          modelMem[id][idx] = data;
          if (int'(idx) + 1 > modelSize[id]) modelSize[id] = int'(idx) + 1;  // Grows
          expData = data;
        end
        heapOpPkg::read: expData = oldValue;
        heapOpPkg::size: expData = heapGeometryPkg::dataT'(modelSize[id]);
        heapOpPkg::push: begin
          modelMem[id][modelSize[id]] = data;
          modelSize[id]++;
          expData = data;
        end
        heapOpPkg::pop: begin
          modelSize[id]--;
          expData = modelMem[id][modelSize[id]];  // Last element
        end
        heapOpPkg::free: begin
          modelAllocated[id] = 1'b0;
          modelFree.push_back(id);
        end
        default: begin  // Read-modify-write ops
          newValue          = applyElementOp(op, oldValue, data);
          modelMem[id][idx] = newValue;
          expData = (op == heapOpPkg::addAfter || op == heapOpPkg::subAfter) ?
                    oldValue : newValue;
        end
      endcase
    end
  endtask

  // --------------------------------------------------------------------------
  // Checking
  // --------------------------------------------------------------------------
  responseTiming: assert property (@(posedge clock) disable iff (!resetN)
      (requestValid && ready) |=> (!ready && !responseValid) ##1 (!ready && responseValid))
    else begin
      protocolErrors++;
      $display("Response did not follow acceptance by two edges at %0t", $time);
    end

  noStrayResponse: assert property (@(posedge clock) disable iff (!resetN)
      responseValid |-> $past(requestValid && ready, 2))
    else begin
      protocolErrors++;
      $display("Response raised without a matching request at %0t", $time);
    end

  // Response check first, prediction at acceptance after it
  always @(posedge clock) begin : responseMonitor
    heapGeometryPkg::dataT expData;
    heapOpPkg::errorCodeT  expError;
    heapOpPkg::opCodeT     expOp;
    if (responseValid) begin
      predictionPending: assert (expDataQueue.size() != 0)
        else begin
          otherErrors++;
          $display("Response arrived with no prediction pending at %0t", $time);
        end
      if (expDataQueue.size() != 0) begin
        expData  = expDataQueue.pop_front();
        expError = expErrorQueue.pop_front();
        expOp    = expOpQueue.pop_front();
        responseMatch: assert (dataOut === expData && errorCode === expError)
          else begin
            mismatchErrors++;
            $display("MISMATCH at %0t: %s returned data %h error %s, expected %h %s",
                     $time, expOp.name(), dataOut, errorCode.name(), expData, expError.name());
          end
      end
    end
    if (resetN && requestValid && ready) begin
      predictResponse(operation, arrayId, elementIndex, dataIn, expData, expError);
      expDataQueue.push_back(expData);
      expErrorQueue.push_back(expError);
      expOpQueue.push_back(operation);
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  // Called just after a rising edge, returns at the response edge
  task automatic doRequest(input heapOpPkg::opCodeT op, input heapGeometryPkg::arrayIdT id,
      input heapGeometryPkg::indexT idx, input heapGeometryPkg::dataT data);
    requestValid <= 1'b1;
    operation    <= op;
    arrayId      <= id;
    elementIndex <= idx;
    dataIn       <= data;
    @(posedge clock);
    while (!ready) @(posedge clock);  // Held until accepted
    requestValid <= 1'b0;
    @(posedge clock);
    while (!responseValid) @(posedge clock);
  endtask

  task automatic reportCounts();
    $display("Errors: mismatch %0d, protocol %0d, other %0d",
             mismatchErrors, protocolErrors, otherErrors);
  endtask

  initial begin : stimulus
    heapOpPkg::opCodeT        op;
    heapGeometryPkg::arrayIdT handle;
    heapGeometryPkg::indexT   index;
    heapGeometryPkg::dataT    operand;
    resetN       = 1'b0;
    requestValid = 1'b0;
    operation    = heapOpPkg::clearAll;
    arrayId      = '0;
    elementIndex = '0;
    dataIn       = '0;
    modelCount   = 0;
    repeat (4) @(posedge clock);
    resetN <= 1'b1;
    @(posedge clock);
    resetIdle: assert (ready === 1'b1 && responseValid === 1'b0 &&
                       errorCode === heapOpPkg::errNone && dataOut === '0)
      else begin
        mismatchErrors++;
        $display("MISMATCH at %0t: outputs not idle after reset", $time);
      end

    // Handles, out of memory, reuse and double free
    doRequest(heapOpPkg::size, 0, 0, 0);      // Nothing allocated yet
    doRequest(heapOpPkg::alloc, 0, 0, 0);
    doRequest(heapOpPkg::alloc, 0, 0, 0);
    doRequest(heapOpPkg::write, 2, 0, 16'h1234);  // Above the count
    doRequest(heapOpPkg::alloc, 0, 0, 0);
    doRequest(heapOpPkg::alloc, 0, 0, 0);
    doRequest(heapOpPkg::alloc, 0, 0, 0);     // Out of memory
    doRequest(heapOpPkg::free, 1, 0, 0);
    doRequest(heapOpPkg::free, 3, 0, 0);
    doRequest(heapOpPkg::alloc, 0, 0, 0);     // Gets 3 back
    doRequest(heapOpPkg::alloc, 0, 0, 0);     // Then 1
    doRequest(heapOpPkg::free, 2, 0, 0);
    doRequest(heapOpPkg::free, 2, 0, 0);      // Double free
    doRequest(heapOpPkg::size, 2, 0, 0);
    doRequest(heapOpPkg::alloc, 0, 0, 0);

    // Size rules on handle 0
    doRequest(heapOpPkg::pop, 0, 0, 0);       // Empty
    doRequest(heapOpPkg::read, 0, 0, 0);      // Past the size
    for (int n = 0; n < heapGeometryPkg::arrayLength; n++)
      doRequest(heapOpPkg::push, 0, 0, heapGeometryPkg::dataT'($random(seed)));
    doRequest(heapOpPkg::push, 0, 0, 16'hbeef);  // Full
    doRequest(heapOpPkg::read, 0, 7, 0);
    doRequest(heapOpPkg::size, 0, 0, 0);
    doRequest(heapOpPkg::pop, 0, 0, 0);
    doRequest(heapOpPkg::size, 0, 0, 0);
    doRequest(heapOpPkg::read, 0, 7, 0);      // Popped slot now out of bounds
    doRequest(heapOpPkg::read, 0, 0, 0);      // Full push wraps to slot 0 if it leaks
    doRequest(heapOpPkg::write, 1, 3, heapGeometryPkg::dataT'($random(seed)));  // Size 4
    doRequest(heapOpPkg::size, 1, 0, 0);
    doRequest(heapOpPkg::read, 1, 3, 0);

    // Random read-modify-write on filled arrays
    for (int n = 0; n < heapGeometryPkg::arrayLength; n++)
      doRequest(heapOpPkg::write, 1, heapGeometryPkg::indexT'(n),
                heapGeometryPkg::dataT'($random(seed)));
    for (int n = 0; n < randomOps; n++) begin
      handle = heapGeometryPkg::arrayIdT'($unsigned($random(seed)) % 2);
      index  = heapGeometryPkg::indexT'($unsigned($random(seed)) % modelSize[handle]);
      op     = heapOpPkg::opCodeT'(int'(heapOpPkg::add) + $unsigned($random(seed)) % 10);
      operand = heapGeometryPkg::dataT'($random(seed));
      if (op == heapOpPkg::shiftLeft || op == heapOpPkg::shiftRight)
        operand = operand & 16'h001f;  // Some amounts past the width
      doRequest(op, handle, index, operand);
      doRequest(heapOpPkg::read, handle, index, 0);
    end

    // Clear everything
    doRequest(heapOpPkg::clearAll, 0, 0, 0);
    for (int n = 0; n < heapGeometryPkg::arrayCount; n++)
      doRequest(heapOpPkg::size, heapGeometryPkg::arrayIdT'(n), 0, 0);
    doRequest(heapOpPkg::alloc, 0, 0, 0);     // Handle 0 again
    doRequest(heapOpPkg::size, 0, 0, 0);

    @(posedge clock);  // Last response checked
    allResponded: assert (expDataQueue.size() == 0)
      else begin
        otherErrors++;
        $display("%0d accepted requests never got a response", expDataQueue.size());
      end
    reportCounts();
    if (mismatchErrors == 0 && protocolErrors == 0 && otherErrors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  initial begin : watchdog
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clock);
      cycleCount++;
    end
    reportCounts();
    $display("Timeout after %0d cycles, the run did not complete", cycleCount);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
common/heapGeometryPkg.sv
common/heapOpPkg.sv
heap/elementStore.sv
heap/elementAlu.sv
heap/arrayDirectory.sv
heap/heapControl.sv
source/heapMemory.sv
verif/heapMemoryTb.sv

// File: Bender.yml
package:
  name: heap_memory

sources:
  # Packages first, then the datapath, control and top level
  - common/heapGeometryPkg.sv
  - common/heapOpPkg.sv
  - heap/elementStore.sv
  - heap/elementAlu.sv
  - heap/arrayDirectory.sv
  - heap/heapControl.sv
  - source/heapMemory.sv

  - target: test
    files:
      - verif/heapMemoryTb.sv
